//--- common/doom_pkg.sv
`default_nettype none

package doom_pkg;

  // bus and data widths
  localparam int ADDR_W      = 32;
  localparam int MEM_DATA_W  = 8;
  localparam int VGA_DATA_W  = 16;
  localparam int HOST_DATA_W = 32;
  localparam int HPS_ADDR_W  = 3;
  localparam int NUM_PARAMS  = 8;

  // palette geometry, 3 bytes per entry in R, G, B order
  localparam int PAL_ENTRIES = 256;
  localparam int PAL_BYTES   = 768;
  localparam int PAL_IDX_W   = 8;
  localparam int PAL_BYTE_W  = 10;  // wide enough to count 768 bytes
  localparam int COLOR_W     = 24;

  localparam int COUNT_W     = 16;  // pixel count, at most 65535

  // host parameter slots
  localparam int PARAM_SRC   = 1;
  localparam int PARAM_COUNT = 2;

  typedef enum logic [1:0] {
    WAITING,
    PALETTE,
    UPDATE,
    RESET
  } state_t;

  typedef enum logic [31:0] {
    CMD_SET_PALETTE   = 32'd1,
    CMD_FINISH_UPDATE = 32'd2,
    CMD_RESET         = 32'd3
  } cmd_t;

endpackage

`default_nettype wire

//--- common/av_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface av_bus_if #(
  parameter int DATA_W = doom_pkg::MEM_DATA_W
);
  logic [doom_pkg::ADDR_W-1:0] address;
  logic                        read;
  logic                        write;
  logic [DATA_W-1:0]           writedata;
  logic [DATA_W-1:0]           readdata;   // valid in the cycle waitrequest is low
  logic                        waitrequest;

  modport master (
    output address, read, write, writedata,
    input  readdata, waitrequest
  );

  modport arbiter (
    input  address, read, write, writedata,
    output readdata, waitrequest
  );
endinterface

`default_nettype wire

//--- src/palette_ram.sv
`timescale 1ns/1ns
`default_nettype none

module palette_ram (
  input  logic                             clk,
  input  logic                             we,
  input  logic [doom_pkg::PAL_IDX_W-1:0]   waddr,
  input  logic [doom_pkg::COLOR_W-1:0]     wdata,
  input  logic [doom_pkg::PAL_IDX_W-1:0]   raddr,
  output logic [doom_pkg::COLOR_W-1:0]     rdata
);

  logic [doom_pkg::COLOR_W-1:0] mem [doom_pkg::PAL_ENTRIES];  // {r, g, b} per entry

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];  // one cycle read latency
  end

endmodule

`default_nettype wire

//--- doom_fpga/palette_loader.sv
`timescale 1ns/1ns
`default_nettype none

module palette_loader (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 start,
  input  logic [doom_pkg::HOST_DATA_W-1:0]     src_addr,
  output logic                                 busy,
  av_bus_if.master                             mem,
  output logic                                 pal_we,
  output logic [doom_pkg::PAL_IDX_W-1:0]       pal_waddr,
  output logic [doom_pkg::COLOR_W-1:0]         pal_wdata
);

  typedef enum logic [1:0] {
    LD_IDLE,
    LD_READ,
    LD_DONE
  } ld_state_t;

  ld_state_t                          state;
  logic [doom_pkg::ADDR_W-1:0]        addr;
  logic [doom_pkg::PAL_BYTE_W-1:0]    byte_cnt;
  logic [1:0]                         phase;     // 0 red, 1 green, 2 blue
  logic [doom_pkg::PAL_IDX_W-1:0]     entry;
  logic [doom_pkg::MEM_DATA_W-1:0]    red;
  logic [doom_pkg::MEM_DATA_W-1:0]    green;
  logic                               rd_done;

  assign rd_done       = mem.read && !mem.waitrequest;
  assign mem.address   = addr;
  assign mem.read      = (state == LD_READ);
  assign mem.write     = 1'b0;
  assign mem.writedata = '0;
  assign busy          = (state == LD_READ);

  // entry goes in as its blue byte arrives
  assign pal_we    = rd_done && phase == 2'd2;
  assign pal_waddr = entry;
  assign pal_wdata = {red, green, mem.readdata};

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= LD_IDLE;
      byte_cnt <= '0;
      phase    <= '0;
      entry    <= '0;
    end else begin
      case (state)
        LD_IDLE: begin
          if (start) begin
            state    <= LD_READ;
            addr     <= src_addr;
            byte_cnt <= '0;
            phase    <= '0;
            entry    <= '0;
          end
        end
        LD_READ: begin
          if (rd_done) begin
            addr     <= addr + 1'b1;
            byte_cnt <= byte_cnt + 1'b1;
            phase    <= (phase == 2'd2) ? 2'd0 : phase + 1'b1;
            if (phase == 2'd2) entry <= entry + 1'b1;
            if (byte_cnt == doom_pkg::PAL_BYTE_W'(doom_pkg::PAL_BYTES - 1)) begin
              state <= LD_DONE;  // last blue byte
            end
          end
        end
        default: state <= LD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_done && phase == 2'd0) red   <= mem.readdata;
    if (rd_done && phase == 2'd1) green <= mem.readdata;
  end

  // each blue byte is the third read of its entry
  a_we_entry: assert property (@(posedge clk) disable iff (rst)
    pal_we |-> 32'(byte_cnt) == 3 * 32'(entry) + 2);

endmodule

`default_nettype wire

//--- doom_fpga/frame_updater.sv
`timescale 1ns/1ns
`default_nettype none

module frame_updater (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  logic [doom_pkg::HOST_DATA_W-1:0]   src_addr,
  input  logic [doom_pkg::COUNT_W-1:0]       count,
  output logic                               busy,
  av_bus_if.master                           mem,
  av_bus_if.master                           vga,
  output logic [doom_pkg::PAL_IDX_W-1:0]     pal_raddr,
  input  logic [doom_pkg::COLOR_W-1:0]       pal_rdata
);

  logic [doom_pkg::COUNT_W-1:0]       f_idx;     // next pixel to fetch
  logic [doom_pkg::COUNT_W-1:0]       w_cnt;     // frame buffer writes done
  logic                               fetching;
  logic                               rd_done;
  logic                               wr_done;

  logic                               s1_v, s2_v, s3_v;
  logic                               s1_adv, s2_adv, s2_free, s3_free;
  logic [doom_pkg::PAL_IDX_W-1:0]     s1_idx, s2_idx;
  logic [doom_pkg::COUNT_W-1:0]       s1_num, s2_num;
  logic [doom_pkg::ADDR_W-1:0]        s3_addr;
  logic [doom_pkg::VGA_DATA_W-1:0]    s3_data;

  assign rd_done = mem.read && !mem.waitrequest;
  assign wr_done = vga.write && !vga.waitrequest;

  // stall chain, each stage moves only if the next one frees up
  assign s3_free = !s3_v || !vga.waitrequest;
  assign s2_free = !s2_v || s3_free;
  assign s2_adv  = s2_v && s3_free;
  assign s1_adv  = s1_v && s2_free;

  assign fetching      = busy && (f_idx != count);
  assign mem.read      = fetching && (!s1_v || s1_adv);  // stays up once raised
  assign mem.address   = src_addr + doom_pkg::ADDR_W'(f_idx);
  assign mem.write     = 1'b0;
  assign mem.writedata = '0;

  // re-present the held index so the ram output follows a stalled lookup
  assign pal_raddr = s1_adv ? s1_idx : s2_idx;

  assign vga.address   = s3_addr;
  assign vga.write     = s3_v;
  assign vga.writedata = s3_data;
  assign vga.read      = 1'b0;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy  <= 1'b0;
      f_idx <= '0;
      w_cnt <= '0;
    end else if (start && !busy) begin
      busy  <= (count != '0);
      f_idx <= '0;
      w_cnt <= '0;
    end else begin
      if (rd_done) f_idx <= f_idx + 1'b1;
      if (wr_done) begin
        w_cnt <= w_cnt + 1'b1;
        if (w_cnt == count - 1'b1) busy <= 1'b0;  // last pixel out
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_v <= 1'b0;
      s2_v <= 1'b0;
      s3_v <= 1'b0;
    end else begin
      if (rd_done) s1_v <= 1'b1;
      else if (s1_adv) s1_v <= 1'b0;
      if (s1_adv) s2_v <= 1'b1;
      else if (s2_adv) s2_v <= 1'b0;
      if (s2_adv) s3_v <= 1'b1;
      else if (s3_free) s3_v <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_done) begin
      s1_idx <= mem.readdata;
      s1_num <= f_idx;
    end
    if (s1_adv) begin
      s2_idx <= s1_idx;
      s2_num <= s1_num;
    end
    if (s2_adv) begin
      s3_addr <= doom_pkg::ADDR_W'(s2_num);
      s3_data <= {pal_rdata[23:19], pal_rdata[15:10], pal_rdata[7:3]};  // rgb565
    end
  end

  a_vga_hold: assert property (@(posedge clk) disable iff (rst)
    vga.write && vga.waitrequest |=> $stable(vga.address) && $stable(vga.writedata));

endmodule

`default_nettype wire

//--- doom_fpga/doom_fpga.sv
`timescale 1ns/1ns
`default_nettype none

module doom_fpga (
  input  logic                                clk,
  input  logic                                main_rst,

  output logic [doom_pkg::ADDR_W-1:0]         mem_address,
  output logic                                mem_read,
  output logic                                mem_write,
  output logic [doom_pkg::MEM_DATA_W-1:0]     mem_writedata,
  input  logic [doom_pkg::MEM_DATA_W-1:0]     mem_readdata,
  input  logic                                mem_waitrequest,

  output logic [doom_pkg::ADDR_W-1:0]         vga_address,
  output logic                                vga_write,
  output logic [doom_pkg::VGA_DATA_W-1:0]     vga_writedata,
  input  logic                                vga_waitrequest,

  input  logic [doom_pkg::HPS_ADDR_W-1:0]     hps_address,
  input  logic                                hps_read,
  input  logic                                hps_write,
  input  logic [doom_pkg::HOST_DATA_W-1:0]    hps_writedata,
  output logic [doom_pkg::HOST_DATA_W-1:0]    hps_readdata,
  output logic                                hps_waitrequest
);

  doom_pkg::state_t state;
  doom_pkg::cmd_t   cmd;
  logic             rst;        // board reset or host reset command
  logic             start_q;    // high in the first cycle of a command
  logic             pal_busy;
  logic             upd_busy;
  logic [doom_pkg::HOST_DATA_W-1:0] params [doom_pkg::NUM_PARAMS];

  logic                          pal_we;
  logic [doom_pkg::PAL_IDX_W-1:0] pal_waddr;
  logic [doom_pkg::COLOR_W-1:0]   pal_wdata;
  logic [doom_pkg::PAL_IDX_W-1:0] pal_raddr;
  logic [doom_pkg::COLOR_W-1:0]   pal_rdata;

  av_bus_if pal_bus ();
  av_bus_if upd_bus ();
  av_bus_if #(.DATA_W(doom_pkg::VGA_DATA_W)) vga_bus ();

  assign rst = main_rst || (hps_write && hps_writedata == doom_pkg::CMD_RESET);
  assign cmd = doom_pkg::cmd_t'(hps_writedata);

  assign hps_waitrequest = (state == doom_pkg::PALETTE) || (state == doom_pkg::UPDATE);
  assign hps_readdata    = hps_read ? params[hps_address] : '0;

  // parameter file, written only while the host is let in
  always_ff @(posedge clk) begin
    if (hps_write && !hps_waitrequest) begin
      params[hps_address] <= hps_writedata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= doom_pkg::RESET;
      start_q <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (state)
        doom_pkg::WAITING, doom_pkg::RESET: begin
          state <= doom_pkg::WAITING;
          if (hps_write && hps_address == '0) begin  // parameter 0 is the command
            case (cmd)
              doom_pkg::CMD_SET_PALETTE: begin
                state   <= doom_pkg::PALETTE;
                start_q <= 1'b1;
              end
              doom_pkg::CMD_FINISH_UPDATE: begin
                state   <= doom_pkg::UPDATE;
                start_q <= 1'b1;
              end
              default: ;
            endcase
          end
        end
        doom_pkg::PALETTE: begin
          if (!start_q && !pal_busy) state <= doom_pkg::WAITING;  // busy is low in the start cycle
        end
        doom_pkg::UPDATE: begin
          if (!start_q && !upd_busy) state <= doom_pkg::WAITING;
        end
        default: state <= doom_pkg::WAITING;
      endcase
    end
  end

  // byte memory goes to whichever handler owns the current state
  always_comb begin
    mem_address           = '0;
    mem_read              = 1'b0;
    mem_write             = 1'b0;
    mem_writedata         = '0;
    pal_bus.readdata      = mem_readdata;
    upd_bus.readdata      = mem_readdata;
    pal_bus.waitrequest   = 1'b1;   // idle handler just sees a stalled bus
    upd_bus.waitrequest   = 1'b1;
    case (state)
      doom_pkg::PALETTE: begin
        mem_address         = pal_bus.address;
        mem_read            = pal_bus.read;
        mem_write           = pal_bus.write;
        mem_writedata       = pal_bus.writedata;
        pal_bus.waitrequest = mem_waitrequest;
      end
      doom_pkg::UPDATE: begin
        mem_address         = upd_bus.address;
        mem_read            = upd_bus.read;
        mem_write           = upd_bus.write;
        mem_writedata       = upd_bus.writedata;
        upd_bus.waitrequest = mem_waitrequest;
      end
      default: ;
    endcase
  end

  assign vga_address         = vga_bus.address;
  assign vga_write           = vga_bus.write;
  assign vga_writedata       = vga_bus.writedata;
  assign vga_bus.waitrequest = vga_waitrequest;
  assign vga_bus.readdata    = '0;  // frame buffer is write only

  palette_loader palette_loader_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start_q && state == doom_pkg::PALETTE),
    .src_addr  (params[doom_pkg::PARAM_SRC]),
    .busy      (pal_busy),
    .mem       (pal_bus.master),
    .pal_we    (pal_we),
    .pal_waddr (pal_waddr),
    .pal_wdata (pal_wdata)
  );

  frame_updater frame_updater_i (
    .clk       (clk),
    .rst       (rst),
    .start     (start_q && state == doom_pkg::UPDATE),
    .src_addr  (params[doom_pkg::PARAM_SRC]),
    .count     (params[doom_pkg::PARAM_COUNT][doom_pkg::COUNT_W-1:0]),
    .busy      (upd_busy),
    .mem       (upd_bus.master),
    .vga       (vga_bus.master),
    .pal_raddr (pal_raddr),
    .pal_rdata (pal_rdata)
  );

  palette_ram palette_ram_i (
    .clk   (clk),
    .we    (pal_we),
    .waddr (pal_waddr),
    .wdata (pal_wdata),
    .raddr (pal_raddr),
    .rdata (pal_rdata)
  );

  // no handler runs while the dispatcher waits for a command
  a_idle_no_busy: assert property (@(posedge clk) disable iff (rst)
    state == doom_pkg::WAITING |-> !pal_busy && !upd_busy);

endmodule

`default_nettype wire

//--- testbench/tb_doom_fpga.sv
`timescale 1ns/1ns
`default_nettype none

module tb_doom_fpga;

  logic        clk = 1'b0;
  logic        main_rst;
  logic [31:0] mem_address;
  logic        mem_read;
  logic        mem_write;
  logic [7:0]  mem_writedata;
  logic [7:0]  mem_readdata;
  logic        mem_waitrequest;
  logic [31:0] vga_address;
  logic        vga_write;
  logic [15:0] vga_writedata;
  logic        vga_waitrequest;
  logic [2:0]  hps_address;
  logic        hps_read;
  logic        hps_write;
  logic [31:0] hps_writedata;
  logic [31:0] hps_readdata;
  logic        hps_waitrequest;

  logic [31:0] stim [256];     // raw words from the stimulus file
  logic [7:0]  mem_image [2048];
  logic [2:0]  cmd_addr [7];
  logic [31:0] cmd_data [7];
  logic [31:0] exp_addr [16];
  logic [31:0] exp_data [16];

  integer      seed = 32'h365;
  logic [31:0] rnd;
  logic        wait_random = 1'b0;
  logic [31:0] rd_base = '0;
  int          rd_count = 0;
  int          wr_count = 0;
  logic        held = 1'b0;    // a frame buffer write is stalled
  logic [31:0] held_addr;
  logic [31:0] held_data;

  doom_fpga doom_fpga_i (.*);

  always #2 clk = ~clk;

  assign mem_readdata = mem_image[mem_address[10:0]];

  // back-pressure on both slave models
  always @(posedge clk) begin
    rnd = $random(seed);
    if (wait_random) begin
      mem_waitrequest <= rnd[0];
      vga_waitrequest <= rnd[1] & rnd[2];
    end else begin
      mem_waitrequest <= 1'b0;
      vga_waitrequest <= 1'b0;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("[ERROR] t=%0t %s actual=%h expected=%h",
                          $time, name, actual, expected));
    end
  endtask

  // one clock edge, then look at both buses as they stood before it
  task automatic clock_step();
    @(posedge clk);
    if (mem_read && !mem_waitrequest) begin
      check_value("mem_address", mem_address, 32'(rd_base + rd_count));
      rd_count++;
    end
    if (vga_write) begin
      if (held) begin
        check_value("vga_address (stalled)", vga_address, held_addr);
        check_value("vga_writedata (stalled)", 32'(vga_writedata), held_data);
      end
      if (vga_waitrequest) begin
        held      = 1'b1;
        held_addr = vga_address;
        held_data = 32'(vga_writedata);
      end else if (wr_count >= 16) begin
        abort_run("frame buffer got more writes than pixels");
      end else begin
        check_value("vga_address", vga_address, exp_addr[wr_count]);
        check_value("vga_writedata", 32'(vga_writedata), exp_data[wr_count]);
        wr_count++;
        held = 1'b0;
      end
    end else begin
      held = 1'b0;
    end
  endtask

  task automatic host_write(input logic [2:0] addr, input logic [31:0] data);
    int cycles;
    cycles        = 0;
    hps_address   <= addr;
    hps_writedata <= data;
    hps_write     <= 1'b1;
    clock_step();
    while (hps_waitrequest) begin  // held until the port lets it in
      if (cycles >= 5000) begin
        abort_run("host write was never accepted");
      end else begin
        clock_step();
        cycles++;
      end
    end
    hps_write <= 1'b0;
  endtask

  task automatic host_read_check(input logic [2:0] addr, input logic [31:0] expected);
    hps_address <= addr;
    hps_read    <= 1'b1;
    clock_step();
    check_value("hps_waitrequest", 32'(hps_waitrequest), 32'd0);
    check_value("hps_readdata", hps_readdata, expected);
    hps_read <= 1'b0;
  endtask

  task automatic wait_idle(input string what, input int limit);
    int cycles;
    cycles = 0;
    clock_step();
    while (hps_waitrequest) begin
      if (cycles >= limit) begin
        abort_run({what, " did not finish in time"});
      end else begin
        clock_step();
        cycles++;
      end
    end
  endtask

  task automatic wait_writes(input int n, input int limit);
    int cycles;
    cycles = 0;
    while (wr_count < n) begin
      if (cycles >= limit) begin
        abort_run("frame buffer writes did not arrive in time");
      end else begin
        clock_step();
        cycles++;
      end
    end
  endtask

  task automatic load_palette();
    rd_base  = cmd_data[1];
    rd_count = 0;
    host_write(cmd_addr[1], cmd_data[1]);
    host_write(cmd_addr[2], cmd_data[2]);
    wait_idle("palette load", 5000);
    check_value("palette reads", 32'(rd_count), 32'(doom_pkg::PAL_BYTES));
    clock_step();
    check_value("hps_waitrequest", 32'(hps_waitrequest), 32'd0);
  endtask

  task automatic run_update();
    rd_base  = cmd_data[3];
    rd_count = 0;
    wr_count = 0;
    host_write(cmd_addr[3], cmd_data[3]);
    host_write(cmd_addr[4], cmd_data[4]);
    host_write(cmd_addr[5], cmd_data[5]);
    wait_idle("frame update", 2000);
    check_value("pixel reads", 32'(rd_count), cmd_data[4]);
    check_value("frame buffer writes", 32'(wr_count), cmd_data[4]);
  endtask

  initial begin
    main_rst        = 1'b1;
    mem_waitrequest = 1'b0;
    vga_waitrequest = 1'b0;
    hps_address     = '0;
    hps_read        = 1'b0;
    hps_write       = 1'b0;
    hps_writedata   = '0;

    $readmemh("testbench/doom_stimulus.txt", stim);
    for (int i = 0; i < 2048; i++) mem_image[i] = 8'(i * 37 + (i >> 8) * 11);
    for (int i = 0; i < 48; i++) mem_image[i] = stim[i][7:0];
    for (int i = 0; i < 16; i++) mem_image[1024 + i] = stim['h40 + i][7:0];
    for (int i = 0; i < 7; i++) begin
      cmd_addr[i] = stim['h50 + 2 * i][2:0];
      cmd_data[i] = stim['h51 + 2 * i];
    end
    for (int i = 0; i < 16; i++) begin
      exp_addr[i] = stim['h60 + 2 * i];
      exp_data[i] = stim['h61 + 2 * i];
    end

    repeat (2) @(posedge clk);
    main_rst <= 1'b0;
    clock_step();
    check_value("mem_read", 32'(mem_read), 32'd0);
    check_value("mem_write", 32'(mem_write), 32'd0);
    check_value("mem_writedata", 32'(mem_writedata), 32'd0);
    check_value("vga_write", 32'(vga_write), 32'd0);
    check_value("hps_waitrequest", 32'(hps_waitrequest), 32'd0);
    host_write(cmd_addr[0], cmd_data[0]);
    host_read_check(cmd_addr[0], cmd_data[0]);

    load_palette();
    run_update();

    wait_random <= 1'b1;
    run_update();

    // reset command lands in the middle of an update
    wait_random <= 1'b0;
    rd_base  = cmd_data[3];
    rd_count = 0;
    wr_count = 0;
    host_write(cmd_addr[5], cmd_data[5]);
    wait_writes(4, 500);
    host_write(cmd_addr[6], cmd_data[6]);
    repeat (8) begin
      clock_step();
      check_value("vga_write", 32'(vga_write), 32'd0);
      check_value("hps_waitrequest", 32'(hps_waitrequest), 32'd0);
    end
    check_value("update cut short", 32'(wr_count < 16), 32'd1);

    load_palette();
    wait_random <= 1'b1;
    run_update();

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/doom_stimulus.txt
// hex words. @00 palette bytes as r g b, @40 pixel indices for byte address 1024
// @50 host writes as address data, @60 expected frame buffer writes as address rgb565
@00
00 00 00  ff ff ff  ff 00 00  00 ff 00   // entries 0 to 3
00 00 ff  12 34 56  80 80 80  a5 5a c3
7f 3f 1f  08 04 08  f0 e0 d0  3c 96 e1
07 03 07  ff 80 01  55 aa 55  c8 64 32   // entries 12 to 15
@40
05 00 0f 01 0a 07 02 0e 03 0d 04 0c 08 0b 07 06
@50
3 0000abcd   // scratch parameter
1 00000000   // palette source
0 00000001   // set palette
1 00000400   // pixel source
2 00000010   // pixel count
0 00000002   // finish update
0 00000003   // reset
@60
00 11aa  01 0000  02 cb26  03 ffff
04 f71a  05 a2d8  06 f800  07 554a
08 07e0  09 fc00  0a 001f  0b 0000
0c 79e3  0d 3cbc  0e a2d8  0f 8410

//--- all.f
common/doom_pkg.sv
common/av_bus_if.sv
src/palette_ram.sv
doom_fpga/palette_loader.sv
doom_fpga/frame_updater.sv
doom_fpga/doom_fpga.sv
testbench/tb_doom_fpga.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module tb_doom_fpga; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_doom_fpga 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1
